//--- source/alu_pkg.sv
// ALU package: widths, class and function codes, and the x86 flags word
`default_nettype none

package alu_pkg;

  // Datapath and code widths
  localparam int data_w  = 16;
  localparam int class_w = 3;
  localparam int func_w  = 3;

  // Operation classes with codes 5 to 7 left illegal
  localparam logic [class_w-1:0] cls_pass   = 3'd0;
  localparam logic [class_w-1:0] cls_addsub = 3'd1;
  localparam logic [class_w-1:0] cls_adjust = 3'd2;
  localparam logic [class_w-1:0] cls_logic  = 3'd3;
  localparam logic [class_w-1:0] cls_shift  = 3'd4;

  // Adjust unit functions
  localparam logic [func_w-1:0] adj_cbw = 3'd0;
  localparam logic [func_w-1:0] adj_aaa = 3'd1;
  localparam logic [func_w-1:0] adj_aas = 3'd2;
  localparam logic [func_w-1:0] adj_cwd = 3'd4;
  localparam logic [func_w-1:0] adj_daa = 3'd5;
  localparam logic [func_w-1:0] adj_das = 3'd6;

  // Logic ops selected by func bits 1:0
  localparam logic [1:0] lg_and = 2'd0;
  localparam logic [1:0] lg_or  = 2'd1;
  localparam logic [1:0] lg_not = 2'd2;
  localparam logic [1:0] lg_xor = 2'd3;

  // Shift ops selected by func bits 1:0
  localparam logic [1:0] sh_sal = 2'd0;
  localparam logic [1:0] sh_sar = 2'd1;
  localparam logic [1:0] sh_shr = 2'd2;

  // x86 flags register layout
  typedef struct packed {
    logic [3:0] rsv_15_12;
    logic       of;
    logic       df;
    logic       if_f;
    logic       tf;
    logic       sf;
    logic       zf;
    logic       rsv_5;
    logic       af;
    logic       rsv_3;
    logic       pf;
    logic       rsv_1;
    logic       cf;
  } flag_bits_t;

  // Same word seen raw or by flag
  typedef union packed {
    logic [data_w-1:0] raw;
    flag_bits_t        bits;
  } flags_t;

endpackage

`default_nettype wire

//--- source/alu_unit_if.sv
// ALU unit interface: operands and incoming flags out, result and flags back
`default_nettype none
`timescale 1ns/10ps

interface alu_unit_if (
  input logic clk
);

  // Operands from the control module
  logic [alu_pkg::data_w-1:0] x;
  logic [alu_pkg::data_w-1:0] y;
  logic [alu_pkg::func_w-1:0] func;
  logic                       word_op;
  logic                       cfi;
  logic                       afi;
  logic                       ofi;

  // Unit results
  logic [alu_pkg::data_w-1:0] res;
  logic [alu_pkg::data_w-1:0] res_hi;
  logic                       cfo;
  logic                       afo;
  logic                       ofo;

  modport ctrl (
    output x, y, func, word_op, cfi, afi, ofi,
    input  res, res_hi, cfo, afo, ofo
  );

  modport unit (
    input  clk, x, y, func, word_op, cfi, afi, ofi,
    output res, res_hi, cfo, afo, ofo
  );

endinterface

`default_nettype wire

//--- source/alu_addsub.sv
// Add and subtract unit: add, adc, sub, sbb, inc, dec with carry, aux and overflow
`default_nettype none
`timescale 1ns/10ps

module alu_addsub (
  alu_unit_if.unit u
);

  logic                       sub;
  logic                       byte_y;
  logic                       use_cf;
  logic                       inc_dec;
  logic                       ci;
  logic [alu_pkg::data_w-1:0] yy;
  logic [alu_pkg::data_w-1:0] op2;
  logic [alu_pkg::data_w:0]   sum;
  logic                       xs;
  logic                       ys;
  logic                       os;

  // func bit 2 selects subtraction
  assign sub     = u.func[2];
  assign byte_y  = (u.func == 3'd3);
  // adc and sbb take the incoming carry
  assign use_cf  = (u.func[1:0] == 2'b00);
  assign inc_dec = (u.func[1:0] == 2'b10);

  assign yy  = byte_y ? {8'h00, u.y[7:0]} : u.y;
  assign op2 = sub ? ~yy : yy;

  // Borrow on sbb enters as an inverted carry
  assign ci = use_cf ? (u.cfi ^ sub) : sub;

  // One adder for every function
  assign sum = {1'b0, u.x} + {1'b0, op2} + {{alu_pkg::data_w{1'b0}}, ci};

  assign u.res    = sum[alu_pkg::data_w-1:0];
  assign u.res_hi = '0;

  // Carry into bit 4, or borrow when subtracting
  assign u.afo = u.x[4] ^ yy[4] ^ sum[4];

  // Byte carry recovered from bit 8 of the sum
  assign u.cfo = inc_dec ? u.cfi
               : (u.word_op ? (sum[alu_pkg::data_w] ^ sub)
                            : (u.x[8] ^ yy[8] ^ sum[8]));

  assign xs = u.word_op ? u.x[15] : u.x[7];
  assign ys = u.word_op ? yy[15]  : yy[7];
  assign os = u.word_op ? sum[15] : sum[7];

  // Overflow when the result sign breaks the operand signs
  assign u.ofo = (xs ^ os) & ~(xs ^ ys ^ sub);

endmodule

`default_nettype wire

//--- source/alu_adjust.sv
// Adjust unit: BCD adjust (aaa, aas, daa, das) and sign extension (cbw, cwd)
`default_nettype none
`timescale 1ns/10ps

module alu_adjust (
  alu_unit_if.unit u
);

  logic                       acond;
  logic                       dcond;
  logic                       borrow_lo;
  logic                       sext;
  logic [alu_pkg::data_w-1:0] aaa_res;
  logic [alu_pkg::data_w-1:0] aas_res;
  logic [7:0]                 daa_tmp;
  logic [7:0]                 das_tmp;
  logic [7:0]                 daa_lo;
  logic [7:0]                 das_lo;
  logic [alu_pkg::data_w-1:0] res;
  logic [alu_pkg::data_w-1:0] res_hi;

  // Low nibble out of BCD range
  assign acond     = (u.x[3:0] > 4'd9) | u.afi;
  // Whole byte out of BCD range
  assign dcond     = (u.x[7:0] > 8'h99) | u.cfi;
  assign borrow_lo = (u.x[7:0] < 8'h06);
  assign sext      = (u.func == alu_pkg::adj_cbw) || (u.func == alu_pkg::adj_cwd);

  // Unpacked BCD where ah takes the carry
  assign aaa_res = (acond ? (u.x + 16'h0106) : u.x) & 16'hff0f;
  assign aas_res = (acond ? (u.x - 16'h0106) : u.x) & 16'hff0f;

  // Packed BCD on al only
  assign daa_tmp = acond ? (u.x[7:0] + 8'h06) : u.x[7:0];
  assign daa_lo  = dcond ? (daa_tmp + 8'h60) : daa_tmp;
  assign das_tmp = acond ? (u.x[7:0] - 8'h06) : u.x[7:0];
  assign das_lo  = dcond ? (das_tmp - 8'h60) : das_tmp;

  always_comb begin
    res_hi = '0;
    case (u.func)
      alu_pkg::adj_cbw: res = {{8{u.x[7]}}, u.x[7:0]};
      alu_pkg::adj_aaa: res = aaa_res;
      alu_pkg::adj_aas: res = aas_res;
      alu_pkg::adj_cwd: begin
        res    = u.x;
        res_hi = {alu_pkg::data_w{u.x[15]}};
      end
      alu_pkg::adj_daa: res = {u.x[15:8], daa_lo};
      alu_pkg::adj_das: res = {u.x[15:8], das_lo};
      default:          res = '0;
    endcase
  end

  assign u.res    = res;
  assign u.res_hi = res_hi;

  // cbw and cwd leave the flags alone
  assign u.afo = sext ? u.afi : acond;
  assign u.cfo = sext ? u.cfi
               : (u.func == alu_pkg::adj_daa) ? dcond
               : (u.func == alu_pkg::adj_das) ? (dcond | (acond & borrow_lo))
               : acond;
  assign u.ofo = 1'b0;

  // Only cwd fills the upper word, and no adjust sets overflow
  a_no_of_hi: assert property (@(posedge u.clk)
    (u.ofo == 1'b0) && ((u.func == alu_pkg::adj_cwd) || (u.res_hi == '0)))
    else $error("adjust unit: overflow or upper word set outside cwd");

endmodule

`default_nettype wire

//--- source/alu_logic_shift.sv
// Logic and shift unit: and, or, not, xor, sal, sar, shr at byte or word width
`default_nettype none
`timescale 1ns/10ps

module alu_logic_shift (
  alu_unit_if.unit u
);

  logic                        is_shift;
  logic [4:0]                  cnt;
  logic                        cnt_zero;
  logic                        sar_fill;
  logic [alu_pkg::data_w-1:0]  logic_res;
  logic [alu_pkg::data_w-1:0]  ext;
  logic [alu_pkg::data_w:0]    sal_w;
  logic [alu_pkg::data_w:0]    shr_w;
  logic signed [alu_pkg::data_w:0] sar_w;
  logic [alu_pkg::data_w-1:0]  shift_res;
  logic                        shift_cf;
  logic                        shift_of;
  logic                        res_sign;
  logic                        x_sign;

  assign is_shift = u.func[2];
  assign cnt      = u.y[4:0];
  assign cnt_zero = (cnt == 5'd0);

  always_comb begin
    case (u.func[1:0])
      alu_pkg::lg_and: logic_res = u.x & u.y;
      alu_pkg::lg_or:  logic_res = u.x | u.y;
      alu_pkg::lg_not: logic_res = ~u.x;
      default:         logic_res = u.x ^ u.y;
    endcase
  end

  // Byte operand widened so that right shifts behave as on 8 bits
  assign sar_fill = (u.func[1:0] == alu_pkg::sh_sar) & u.x[7];
  assign ext      = u.word_op ? u.x : {{8{sar_fill}}, u.x[7:0]};

  // Extra bit catches the last bit shifted out
  assign sal_w = {1'b0, ext} << cnt;
  assign shr_w = {ext, 1'b0} >> cnt;
  assign sar_w = $signed({ext, 1'b0}) >>> cnt;

  always_comb begin
    case (u.func[1:0])
      alu_pkg::sh_sal: begin
        shift_res = u.word_op ? sal_w[15:0] : {8'h00, sal_w[7:0]};
        shift_cf  = u.word_op ? sal_w[16] : sal_w[8];
      end
      alu_pkg::sh_sar: begin
        shift_res = sar_w[16:1];
        shift_cf  = sar_w[0];
      end
      default: begin
        shift_res = shr_w[16:1];
        shift_cf  = shr_w[0];
      end
    endcase
  end

  assign res_sign = u.word_op ? shift_res[15] : shift_res[7];
  assign x_sign   = u.word_op ? u.x[15] : u.x[7];

  always_comb begin
    case (u.func[1:0])
      alu_pkg::sh_sal: shift_of = res_sign ^ shift_cf;
      alu_pkg::sh_sar: shift_of = 1'b0;
      default:         shift_of = x_sign;
    endcase
  end

  assign u.res    = is_shift ? shift_res : logic_res;
  assign u.res_hi = '0;

  // Zero count leaves every flag as it was
  assign u.cfo = is_shift ? (cnt_zero ? u.cfi : shift_cf) : 1'b0;
  assign u.ofo = is_shift ? (cnt_zero ? u.ofi : shift_of) : 1'b0;
  assign u.afo = (is_shift && cnt_zero) ? u.afi : 1'b0;

endmodule

`default_nettype wire

//--- source/alu_ctrl.sv
// ALU control: operand register, unit result select, flag merge and result register
`default_nettype none
`timescale 1ns/10ps

module alu_ctrl (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           go,
  input  logic [alu_pkg::class_w-1:0]    t,
  input  logic [alu_pkg::func_w-1:0]     func,
  input  logic                           word_op,
  input  logic [alu_pkg::data_w-1:0]     x,
  input  logic [alu_pkg::data_w-1:0]     y,
  input  alu_pkg::flags_t                iflags,
  output logic                           res_valid,
  output logic [2*alu_pkg::data_w-1:0]   out,
  output alu_pkg::flags_t                oflags,
  alu_unit_if.ctrl                       add_u,
  alu_unit_if.ctrl                       adj_u,
  alu_unit_if.ctrl                       ls_u
);

  logic [alu_pkg::class_w-1:0]  t_r;
  logic [alu_pkg::func_w-1:0]   func_r;
  logic                         word_op_r;
  logic [alu_pkg::data_w-1:0]   x_r;
  logic [alu_pkg::data_w-1:0]   y_r;
  alu_pkg::flags_t              iflags_r;
  logic                         stage_v;
  logic [alu_pkg::data_w-1:0]   sel_res;
  logic [alu_pkg::data_w-1:0]   sel_hi;
  logic                         sel_cf;
  logic                         sel_af;
  logic                         sel_of;
  logic                         keep_all;
  logic                         keep_szp;
  logic                         wide;
  alu_pkg::flags_t              next_flags;

  // Stage 1 valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_v <= 1'b0;
    end else begin
      stage_v <= go;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      t_r       <= t;
      func_r    <= func;
      word_op_r <= word_op;
      x_r       <= x;
      y_r       <= y;
      iflags_r  <= iflags;
    end
  end

  // Same operands to every unit
  assign add_u.x       = x_r;
  assign add_u.y       = y_r;
  assign add_u.func    = func_r;
  assign add_u.word_op = word_op_r;
  assign add_u.cfi     = iflags_r.bits.cf;
  assign add_u.afi     = iflags_r.bits.af;
  assign add_u.ofi     = iflags_r.bits.of;

  assign adj_u.x       = x_r;
  assign adj_u.y       = y_r;
  assign adj_u.func    = func_r;
  assign adj_u.word_op = word_op_r;
  assign adj_u.cfi     = iflags_r.bits.cf;
  assign adj_u.afi     = iflags_r.bits.af;
  assign adj_u.ofi     = iflags_r.bits.of;

  // Shift class sets func bit 2 of the logic and shift unit
  assign ls_u.x        = x_r;
  assign ls_u.y        = y_r;
  assign ls_u.func     = {t_r == alu_pkg::cls_shift, func_r[1:0]};
  assign ls_u.word_op  = word_op_r;
  assign ls_u.cfi      = iflags_r.bits.cf;
  assign ls_u.afi      = iflags_r.bits.af;
  assign ls_u.ofi      = iflags_r.bits.of;

  always_comb begin
    sel_res = '0;
    sel_hi  = '0;
    sel_cf  = iflags_r.bits.cf;
    sel_af  = iflags_r.bits.af;
    sel_of  = iflags_r.bits.of;
    case (t_r)
      alu_pkg::cls_pass: sel_res = {8'h00, y_r[7:0]};
      alu_pkg::cls_addsub: begin
        sel_res = add_u.res;
        sel_hi  = add_u.res_hi;
        sel_cf  = add_u.cfo;
        sel_af  = add_u.afo;
        sel_of  = add_u.ofo;
      end
      alu_pkg::cls_adjust: begin
        sel_res = adj_u.res;
        sel_hi  = adj_u.res_hi;
        sel_cf  = adj_u.cfo;
        sel_af  = adj_u.afo;
        sel_of  = adj_u.ofo;
      end
      alu_pkg::cls_logic, alu_pkg::cls_shift: begin
        sel_res = ls_u.res;
        sel_hi  = ls_u.res_hi;
        sel_cf  = ls_u.cfo;
        sel_af  = ls_u.afo;
        sel_of  = ls_u.ofo;
      end
      default: sel_res = '0;
    endcase
  end

  assign keep_all = (t_r == alu_pkg::cls_pass) || (t_r > alu_pkg::cls_shift);
  assign keep_szp = keep_all
                 || (t_r == alu_pkg::cls_logic && func_r == {1'b0, alu_pkg::lg_not})
                 || (t_r == alu_pkg::cls_shift && y_r[4:0] == 5'd0);
  // Adjust results are judged on al
  assign wide     = word_op_r && (t_r != alu_pkg::cls_adjust);

  always_comb begin
    next_flags         = iflags_r;
    next_flags.bits.cf = sel_cf;
    next_flags.bits.af = sel_af;
    next_flags.bits.of = sel_of;
    if (!keep_szp) begin
      next_flags.bits.pf = ~^sel_res[7:0];
      next_flags.bits.zf = wide ? (sel_res == '0) : (sel_res[7:0] == 8'h00);
      next_flags.bits.sf = wide ? sel_res[15] : sel_res[7];
    end
  end

  // Result register one cycle after the operands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid  <= 1'b0;
      out        <= '0;
      oflags.raw <= '0;
    end else begin
      res_valid <= stage_v;
      if (stage_v) begin
        out    <= {sel_hi, sel_res};
        oflags <= next_flags;
      end
    end
  end

  a_legal_class: assert property (@(posedge clk) disable iff (!arst_n)
    go |-> (t <= alu_pkg::cls_shift))
    else $error("illegal class code %0d with go", t);

  // A result follows its go by exactly two edges
  a_valid_after_go: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid |-> $past(go, 2))
    else $error("res_valid without a go two edges earlier");

endmodule

`default_nettype wire

//--- source/alu_top.sv
// ALU top level: control module joined to the add, adjust and logic/shift units
`default_nettype none
`timescale 1ns/10ps

module alu_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          go,
  input  logic [alu_pkg::class_w-1:0]   t,
  input  logic [alu_pkg::func_w-1:0]    func,
  input  logic                          word_op,
  input  logic [alu_pkg::data_w-1:0]    x,
  input  logic [alu_pkg::data_w-1:0]    y,
  input  logic [alu_pkg::data_w-1:0]    iflags,
  output logic                          res_valid,
  output logic [2*alu_pkg::data_w-1:0]  out,
  output logic [alu_pkg::data_w-1:0]    oflags
);

  // One link per datapath unit
  alu_unit_if add_if (.clk(clk));
  alu_unit_if adj_if (.clk(clk));
  alu_unit_if ls_if  (.clk(clk));

  alu_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (go),
    .t         (t),
    .func      (func),
    .word_op   (word_op),
    .x         (x),
    .y         (y),
    .iflags    (iflags),
    .res_valid (res_valid),
    .out       (out),
    .oflags    (oflags),
    .add_u     (add_if),
    .adj_u     (adj_if),
    .ls_u      (ls_if)
  );

  alu_addsub      u_addsub (.u(add_if));
  alu_adjust      u_adjust (.u(adj_if));
  alu_logic_shift u_lshift (.u(ls_if));

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
// Testbench clock and reset: 10 ns clock, arst_n held low for 8 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset released on a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/alu_tb.sv
// ALU testbench: reads vectors, drives the ALU in bursts and checks results in order
`timescale 1ns/10ps
`default_nettype none

module alu_tb;

  localparam int n_fields   = 8;
  localparam int max_vec    = 32;
  localparam int wait_limit = 100;

  logic                              clk;
  logic                              arst_n;
  logic                              go;
  logic [alu_pkg::class_w-1:0]       t;
  logic [alu_pkg::func_w-1:0]        func;
  logic                              word_op;
  logic [alu_pkg::data_w-1:0]        x;
  logic [alu_pkg::data_w-1:0]        y;
  logic [alu_pkg::data_w-1:0]        iflags;
  logic                              res_valid;
  logic [2*alu_pkg::data_w-1:0]      out;
  logic [alu_pkg::data_w-1:0]        oflags;

  // Fields per vector are class, func, word_op, x, y, iflags, out and flags
  logic [31:0] vec_mem [0:max_vec*n_fields-1];
  int          n_vec;

  // Pending results in issue order
  logic [31:0] exp_out_q [$];
  logic [15:0] exp_flags_q [$];
  int          exp_idx_q [$];
  int          go_edge_q [$];

  int cyc;
  int received;
  int test_checks;
  int test_errors;
  int total_checks;
  int total_errors;
  int i;

  tb_clkgen u_clkgen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  alu_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (go),
    .t         (t),
    .func      (func),
    .word_op   (word_op),
    .x         (x),
    .y         (y),
    .iflags    (iflags),
    .res_valid (res_valid),
    .out       (out),
    .oflags    (oflags)
  );

  function automatic string flag_text(input alu_pkg::flags_t f);
    return $sformatf("of=%0b sf=%0b zf=%0b af=%0b pf=%0b cf=%0b",
                     f.bits.of, f.bits.sf, f.bits.zf, f.bits.af, f.bits.pf, f.bits.cf);
  endfunction

  task automatic check_result();
    logic [31:0] e_out;
    logic [15:0] e_flags;
    int          idx;
    int          go_n;
    assert (exp_out_q.size() != 0) else begin
      $display("res_valid was high at %0t with no operation pending", $time);
      test_errors++;
    end
    if (exp_out_q.size() != 0) begin
      e_out   = exp_out_q.pop_front();
      e_flags = exp_flags_q.pop_front();
      idx     = exp_idx_q.pop_front();
      go_n    = -10;
      if (go_edge_q.size() != 0) begin
        go_n = go_edge_q.pop_front();
      end
      received++;
      test_checks += 3;
      assert (out == e_out) else begin
        $display("mismatch at %0t: vector %0d out %h, expected %h", $time, idx, out, e_out);
        test_errors++;
      end
      assert (oflags == e_flags) else begin
        $display("mismatch at %0t: vector %0d flags %h (%s), expected %h (%s)", $time, idx,
                 oflags, flag_text(oflags), e_flags, flag_text(e_flags));
        test_errors++;
      end
      // Sampled two edges after the edge that took go
      assert (cyc == go_n + 2) else begin
        $display("Result of vector %0d arrived %0d edges after its go edge instead of 2",
                 idx, cyc - go_n);
        test_errors++;
      end
    end
  endtask

  // Monitor reading values from before the edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (go) begin
      go_edge_q.push_back(cyc);
    end
    if (res_valid) begin
      check_result();
    end
  end

  task automatic drive_vector(input int idx, input logic [15:0] flip,
                              input logic [15:0] set_bits);
    int base;
    base = idx * n_fields;
    @(posedge clk);
    go      <= 1'b1;
    t       <= vec_mem[base][2:0];
    func    <= vec_mem[base+1][2:0];
    word_op <= vec_mem[base+2][0];
    x       <= vec_mem[base+3][15:0];
    y       <= vec_mem[base+4][15:0];
    iflags  <= (vec_mem[base+5][15:0] ^ flip) | set_bits;
    exp_out_q.push_back(vec_mem[base+6]);
    // df, if_f and tf pass straight through
    exp_flags_q.push_back(vec_mem[base+7][15:0] ^ flip);
    exp_idx_q.push_back(idx);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    go <= 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("test %-10s %0d checks, %0d errors", name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  task automatic wait_results(input string name);
    int n;
    n = 0;
    while (exp_out_q.size() != 0 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_out_q.size() != 0) begin
      $display("Timed out in test %s with %0d results never delivered", name,
               exp_out_q.size());
      test_errors++;
      exp_out_q.delete();
      exp_flags_q.delete();
      exp_idx_q.delete();
      go_edge_q.delete();
    end
  endtask

  task automatic check_reset();
    int n;
    test_checks = 0;
    test_errors = 0;
    n = 0;
    while (!arst_n && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!arst_n) begin
      $display("Reset was not released within %0d cycles", wait_limit);
      test_errors++;
    end
    repeat (3) begin
      @(negedge clk);
      test_checks++;
      assert (res_valid == 1'b0 && out == '0 && oflags == '0) else begin
        $display("mismatch at %0t: after reset res_valid %b out %h flags %h, expected zero",
                 $time, res_valid, out, oflags);
        test_errors++;
      end
    end
    report_test("reset");
  endtask

  task automatic run_group(input string name, input int cls_lo, input int cls_hi,
                           input int gap, input logic [15:0] flip,
                           input logic [15:0] set_bits);
    int cls;
    int issued;
    int k;
    test_checks = 0;
    test_errors = 0;
    received    = 0;
    issued      = 0;
    for (k = 0; k < n_vec; k++) begin
      cls = vec_mem[k*n_fields];
      if (cls >= cls_lo && cls <= cls_hi) begin
        drive_vector(k, flip, set_bits);
        issued++;
        repeat (gap) idle_cycle();
      end
    end
    idle_cycle();
    wait_results(name);
    // Quiet cycles catch a stray res_valid
    repeat (3) @(negedge clk);
    test_checks++;
    assert (issued > 0 && received == issued) else begin
      $display("Test %s issued %0d vectors but saw %0d results", name, issued, received);
      test_errors++;
    end
    report_test(name);
  endtask

  initial begin
    go           = 1'b0;
    t            = '0;
    func         = '0;
    word_op      = 1'b0;
    x            = '0;
    y            = '0;
    iflags       = '0;
    cyc          = 0;
    total_checks = 0;
    total_errors = 0;

    // All ones in the class field marks the end of the vectors
    for (i = 0; i < max_vec*n_fields; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("sim/alu_stimulus.mem", vec_mem);
    n_vec = 0;
    while (n_vec < max_vec && vec_mem[n_vec*n_fields] != 32'hffff_ffff) begin
      n_vec++;
    end

    check_reset();
    run_group("pass_add", 0, 1, 1, 16'h0000, 16'h0000);
    // Adjust always clears an incoming of
    run_group("adjust", 2, 2, 1, 16'h0000, 16'h0800);
    run_group("logic", 3, 4, 1, 16'h0000, 16'h0000);
    // Every vector back to back with control flags toggled
    run_group("burst", 0, 4, 0, 16'h0700, 16'h0000);

    $display("summary: %0d vectors, %0d checks, %0d errors", n_vec, total_checks,
             total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/alu_pkg.sv
source/alu_unit_if.sv
source/alu_addsub.sv
source/alu_adjust.sv
source/alu_logic_shift.sv
source/alu_ctrl.sv
source/alu_top.sv
sim/tb_clkgen.sv
sim/alu_tb.sv

//--- run.sh
#!/bin/sh
# Builds the ALU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module alu_tb -o alu_sim

sim_out=$(./obj_dir/alu_sim)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- sim/alu_stimulus.mem
// class func word_op x y iflags expected_out expected_flags
// One vector per line, all fields in hex
0 0 1 1234 abcd 0ad5 000000cd 0ad5
1 1 1 7fff 0001 0200 00008000 0a94
1 1 0 00ff 0001 0200 00000100 0255
1 0 1 1234 0f0f 0201 00002144 0214
1 4 1 0000 0000 0201 0000ffff 0295
1 5 1 8000 8000 0200 00000000 0244
1 2 1 00ff 0001 0201 00000100 0215
1 6 0 0080 0001 0200 0000007f 0a10
1 3 1 1000 ff80 0200 00001080 0200
2 5 0 129a 0000 0200 00001200 0255
2 6 0 00f5 0000 0201 00000095 0285
2 1 0 000b 0000 0200 00000101 0211
2 2 0 02ff 0000 0210 00000109 0215
2 0 0 1280 0000 0201 0000ff80 0281
2 4 1 8001 0000 0210 ffff8001 0210
3 0 1 f0f0 8f81 0a11 00008080 0280
3 2 1 00ff 0000 0ad5 0000ff00 02c4
4 0 1 4001 0002 0200 00000004 0a01
4 1 0 1294 0003 0200 0000fff2 0281
4 2 1 8003 0001 0200 00004001 0a01
4 0 1 1234 0020 0fd5 00001234 0fd5
